// ==== compile.f ====
hdl/top_pkg.sv
hdl/acc_cpu.sv
hdl/axi_single_master.sv
hdl/top_core.sv
hdl/top.sv
bench/top_sva.sv
bench/top_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module top_tb -f compile.f -o top_tb

run:
	./obj_dir/top_tb

clean:
	rm -rf obj_dir

// ==== bench/top_tb.sv ====
`timescale 1ns/1ps

module top_tb;
  import top_pkg::*;

  localparam int    NUM_ROWS    = 4;
  localparam int    PROG_WORDS  = 12;
  localparam int    ISR_WORDS   = 6;
  localparam int    CYCLE_LIMIT = 400 * NUM_ROWS;
  localparam addr_t RESET_PC    = 32'h0000_0000;
  localparam addr_t IRQ_VEC     = 32'h0000_0100;
  localparam addr_t MBOX        = 32'h0000_0FFC;

  logic        clock = 1'b0;
  logic        arst_n = 1'b0;
  logic        io_interrupt = 1'b0;
  logic        io_master_arready = 1'b0, io_master_rvalid = 1'b0, io_master_rlast = 1'b1;
  logic        io_master_awready = 1'b0, io_master_wready = 1'b0, io_master_bvalid = 1'b0;
  logic [1:0]  io_master_rresp = resp_okay, io_master_bresp = resp_okay;
  logic [3:0]  io_master_rid = 4'h0, io_master_bid = 4'h0;
  word_t       io_master_rdata = '0;
  logic        io_master_arvalid, io_master_rready, io_master_awvalid;
  logic        io_master_wvalid, io_master_wlast, io_master_bready;
  addr_t       io_master_araddr, io_master_awaddr;
  word_t       io_master_wdata;
  logic [3:0]  io_master_arid, io_master_awid, io_master_wstrb;
  logic [7:0]  io_master_arlen, io_master_awlen;
  logic [2:0]  io_master_arsize, io_master_awsize;
  logic [1:0]  io_master_arburst, io_master_awburst;
  logic        io_slave_arvalid = 1'b0, io_slave_rready = 1'b0, io_slave_awvalid = 1'b0;
  logic        io_slave_wvalid = 1'b0, io_slave_wlast = 1'b0, io_slave_bready = 1'b0;
  logic [31:0] io_slave_araddr = '0, io_slave_awaddr = '0, io_slave_wdata = '0;
  logic [3:0]  io_slave_arid = '0, io_slave_awid = '0;
  logic [7:0]  io_slave_arlen = '0, io_slave_awlen = '0, io_slave_wstrb = '0;
  logic [2:0]  io_slave_arsize = '0, io_slave_awsize = '0;
  logic [1:0]  io_slave_arburst = '0, io_slave_awburst = '0;
  logic        io_slave_arready, io_slave_rvalid, io_slave_rlast;
  logic        io_slave_awready, io_slave_wready, io_slave_bvalid;
  logic [1:0]  io_slave_rresp, io_slave_bresp;
  logic [3:0]  io_slave_rid, io_slave_bid;
  word_t       io_slave_rdata;

  // Test table, one row per program
  instr_u prog [NUM_ROWS][PROG_WORDS];
  instr_u isr [NUM_ROWS][ISR_WORDS];
  addr_t  preset_addr [NUM_ROWS][2];
  word_t  preset_val [NUM_ROWS][2];
  int     irq_cycle [NUM_ROWS];  // Cycle after reset release, -1 for none
  addr_t  mbox_addr [NUM_ROWS];
  word_t  mbox_val [NUM_ROWS];

  word_t mem [1024];
  int    cur_row = 0;
  int    cycles = 0;
  int    row_cycle = 0;
  int    rd_count = 0;
  int    ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic  ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic  r_pend, aw_got, w_got, b_pend, fetched, mbox_seen;
  addr_t rd_addr, wr_addr, first_fetch;
  word_t wr_data, mbox_data;

  top #(
    .RESET_PC (RESET_PC),
    .IRQ_VEC  (IRQ_VEC)
  ) dut_i (.*);

  always #50 clock = ~clock;

  function automatic instr_u enc_imm(input opcode_e op, input int imm);
    instr_u w;
    w.imm.op  = op;
    w.imm.imm = imm[27:0];
    return w;
  endfunction

  function automatic instr_u enc_mem(input opcode_e op, input addr_t a);
    instr_u w;
    w.mem.op   = op;
    w.mem.addr = a[27:0];
    return w;
  endfunction

  function automatic int random_delay();
    return int'($urandom % 4);
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic build_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < PROG_WORDS; i++) prog[r][i] = enc_imm(HALT, 0);
      for (int i = 0; i < ISR_WORDS; i++) isr[r][i] = enc_imm(HALT, 0);
      preset_addr[r] = '{32'h3F0, 32'h3F4};
      preset_val[r]  = '{32'h0, 32'h0};
      irq_cycle[r]   = -1;
      mbox_addr[r]   = MBOX;
    end
    // Negative immediates, the last one is the most negative 28-bit value
    prog[0][0:3] = '{enc_imm(LDI, -5), enc_imm(ADDI, -7), enc_imm(ADDI, -134217728),
                     enc_mem(STORE, MBOX)};
    mbox_val[0]  = 32'hF7FF_FFF4;
    // Sum of two memory words wraps past 2**32
    prog[1][0:2]   = '{enc_mem(LOAD, 32'h200), enc_mem(ADD, 32'h204), enc_mem(STORE, MBOX)};
    preset_addr[1] = '{32'h200, 32'h204};
    preset_val[1]  = '{32'hFFFF_FFF0, 32'h0000_0025};
    mbox_val[1]    = 32'h0000_0015;
    // Countdown in acc, the iteration count lives at 0x304
    prog[2][0:9] = '{enc_imm(LDI, 3), enc_mem(STORE, 32'h300), enc_mem(LOAD, 32'h304),
                     enc_imm(ADDI, 1), enc_mem(STORE, 32'h304), enc_mem(LOAD, 32'h300),
                     enc_imm(ADDI, -1), enc_mem(BNZ, 32'h4), enc_mem(LOAD, 32'h304),
                     enc_mem(STORE, MBOX)};
    preset_addr[2] = '{32'h300, 32'h304};
    mbox_val[2]    = 32'd3;
    // Handler saves acc, adds 0x40 to the word at 0x308 and restores acc
    prog[3][0:4] = '{enc_imm(LDI, 6), enc_imm(ADDI, -1), enc_mem(BNZ, 32'h4),
                     enc_mem(LOAD, 32'h308), enc_mem(STORE, MBOX)};
    isr[3]       = '{enc_mem(STORE, 32'h30C), enc_mem(LOAD, 32'h308), enc_imm(ADDI, 32'h40),
                     enc_mem(STORE, 32'h308), enc_mem(LOAD, 32'h30C), enc_imm(RETI, 0)};
    preset_addr[3] = '{32'h308, 32'h30C};
    preset_val[3]  = '{32'h0000_1000, 32'h0};
    irq_cycle[3]   = 30;
    mbox_val[3]    = 32'h0000_1040;
  endtask

  task automatic load_memory(input int row);
    for (int i = 0; i < 1024; i++) mem[i] = {HALT, 28'(i * 4)};
    for (int i = 0; i < PROG_WORDS; i++) mem[i] = prog[row][i];
    for (int i = 0; i < ISR_WORDS; i++) mem[IRQ_VEC[11:2] + 10'(i)] = isr[row][i];
    for (int j = 0; j < 2; j++) mem[preset_addr[row][j][11:2]] = preset_val[row][j];
  endtask

  // AXI slave memory with random ready and valid delays
  always @(negedge clock) begin
    if (!arst_n) begin
      load_memory(cur_row);
      io_interrupt      = 1'b0;
      io_master_arready = 1'b0;
      io_master_rvalid  = 1'b0;
      io_master_awready = 1'b0;
      io_master_wready  = 1'b0;
      io_master_bvalid  = 1'b0;
      {ar_fire, r_fire, aw_fire, w_fire, b_fire} = '0;
      {r_pend, aw_got, w_got, b_pend, fetched, mbox_seen} = '0;
      ar_wait   = random_delay();
      aw_wait   = random_delay();
      w_wait    = random_delay();
      row_cycle = 0;
    end else begin
      row_cycle++;
      if (irq_cycle[cur_row] >= 0 && row_cycle == irq_cycle[cur_row]) io_interrupt = 1'b1;
      // Transfers completed at the last rising edge
      if (ar_fire) begin
        io_master_arready = 1'b0;
        ar_wait = random_delay();
        r_wait  = random_delay();
        r_pend  = 1'b1;
      end
      if (r_fire) begin
        io_master_rvalid = 1'b0;
        rd_count++;
      end
      if (aw_fire) begin
        io_master_awready = 1'b0;
        aw_wait = random_delay();
        aw_got  = 1'b1;
      end
      if (w_fire) begin
        io_master_wready = 1'b0;
        w_wait = random_delay();
        w_got  = 1'b1;
      end
      if (aw_got && w_got) begin
        mem[wr_addr[11:2]] = wr_data;
        {aw_got, w_got} = '0;
        b_wait = random_delay();
        b_pend = 1'b1;
      end
      if (b_fire) begin
        io_master_bvalid = 1'b0;
        if (wr_addr == mbox_addr[cur_row]) begin
          mbox_seen = 1'b1;
          mbox_data = wr_data;
        end
      end
      // Ready and valid for the next rising edge
      if (io_master_arvalid && !io_master_arready) begin
        if (ar_wait == 0) io_master_arready = 1'b1;
        else ar_wait--;
      end
      if (io_master_awvalid && !io_master_awready) begin
        if (aw_wait == 0) io_master_awready = 1'b1;
        else aw_wait--;
      end
      if (io_master_wvalid && !io_master_wready) begin
        if (w_wait == 0) io_master_wready = 1'b1;
        else w_wait--;
      end
      if (r_pend) begin
        if (r_wait == 0) begin
          io_master_rvalid = 1'b1;
          io_master_rdata  = mem[rd_addr[11:2]];
          r_pend = 1'b0;
        end else begin
          r_wait--;
        end
      end
      if (b_pend) begin
        if (b_wait == 0) begin
          io_master_bvalid = 1'b1;
          b_pend = 1'b0;
        end else begin
          b_wait--;
        end
      end
      ar_fire = io_master_arvalid && io_master_arready;
      r_fire  = io_master_rvalid && io_master_rready;
      aw_fire = io_master_awvalid && io_master_awready;
      w_fire  = io_master_wvalid && io_master_wready;
      b_fire  = io_master_bvalid && io_master_bready;
      if (ar_fire) begin
        rd_addr = io_master_araddr;
        if (!fetched) first_fetch = io_master_araddr;
        fetched = 1'b1;
        if (io_master_araddr == IRQ_VEC) io_interrupt = 1'b0;  // Handler entry acks the line
        check_word({15'h0, io_master_arid, io_master_arlen, io_master_arsize, io_master_arburst},
                   {15'h0, 4'h0, 8'h00, 3'd2, 2'b01}, "AR id, len, size and burst");
      end
      if (aw_fire) begin
        wr_addr = io_master_awaddr;
        check_word({15'h0, io_master_awid, io_master_awlen, io_master_awsize, io_master_awburst},
                   {15'h0, 4'h0, 8'h00, 3'd2, 2'b01}, "AW id, len, size and burst");
      end
      if (w_fire) begin
        wr_data = io_master_wdata;
        check_word({27'h0, io_master_wstrb, io_master_wlast}, {27'h0, 4'hf, 1'b1},
                   "W strobe and last");
      end
    end
  end

  always @(negedge clock) begin
    check_word(io_slave_rdata, '0, "io_slave_rdata");
    check_word({14'h0, io_slave_arready, io_slave_rvalid, io_slave_rresp, io_slave_rlast,
                io_slave_rid, io_slave_awready, io_slave_wready, io_slave_bvalid,
                io_slave_bresp, io_slave_bid}, '0, "io_slave control outputs");
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  task automatic run_row(input int row);
    int base;
    @(negedge clock);
    cur_row = row;
    arst_n  = 1'b0;
    repeat (8) @(negedge clock);
    arst_n = 1'b1;
    while (!mbox_seen) @(negedge clock);
    check_addr(first_fetch, RESET_PC, "first fetch address");
    check_word(mbox_data, mbox_val[row], "mailbox value");
    base = rd_count;
    while (rd_count == base) @(negedge clock);  // Fetch of the HALT word
    repeat (50) begin
      @(negedge clock);
      check_word({30'h0, io_master_arvalid, io_master_awvalid}, '0, "AR/AW valid after HALT");
    end
  endtask

  initial begin
    void'($urandom(32'h7126_efd9));
    build_table();
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== bench/top_sva.sv ====
`timescale 1ns/1ps

module top_sva (
  input logic           clk,
  input logic           arst_n,
  input logic           req,
  input logic           done,
  input logic           arvalid,
  input logic           arready,
  input top_pkg::addr_t araddr,
  input logic           awvalid,
  input logic           awready,
  input top_pkg::addr_t awaddr,
  input logic           wvalid,
  input logic           wready,
  input top_pkg::word_t wdata_out,
  input logic           wlast
);

  logic busy;  // Request taken, done not yet seen

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
    end else if (req) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr changed before arready");

  aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    wvalid && !wready |=> wvalid && $stable(wdata_out))
    else $error("wvalid dropped or wdata changed before wready");

  w_last: assert property (@(posedge clk) disable iff (!arst_n) wvalid |-> wlast)
    else $error("wlast low on a single-beat write");

  one_req: assert property (@(posedge clk) disable iff (!arst_n) req |-> !busy)
    else $error("second request before done");

  done_req: assert property (@(posedge clk) disable iff (!arst_n) done |-> busy)
    else $error("done without a request");

endmodule

bind axi_single_master top_sva sva_i (.*);

// ==== hdl/top.sv ====
`timescale 1ns/1ps

module top #(
  parameter top_pkg::addr_t RESET_PC = 32'h0000_0000,
  parameter top_pkg::addr_t IRQ_VEC  = 32'h0000_0100
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [31:0] io_master_araddr,
  output logic [3:0]  io_master_arid,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [1:0]  io_master_rresp,
  input  logic [31:0] io_master_rdata,
  input  logic        io_master_rlast,
  input  logic [3:0]  io_master_rid,
  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [31:0] io_master_awaddr,
  output logic [3:0]  io_master_awid,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [31:0] io_master_wdata,
  output logic [3:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [1:0]  io_master_bresp,
  input  logic [3:0]  io_master_bid,
  output logic        io_slave_arready,
  input  logic        io_slave_arvalid,
  input  logic [31:0] io_slave_araddr,
  input  logic [3:0]  io_slave_arid,
  input  logic [7:0]  io_slave_arlen,
  input  logic [2:0]  io_slave_arsize,
  input  logic [1:0]  io_slave_arburst,
  input  logic        io_slave_rready,
  output logic        io_slave_rvalid,
  output logic [1:0]  io_slave_rresp,
  output logic [31:0] io_slave_rdata,
  output logic        io_slave_rlast,
  output logic [3:0]  io_slave_rid,
  output logic        io_slave_awready,
  input  logic        io_slave_awvalid,
  input  logic [31:0] io_slave_awaddr,
  input  logic [3:0]  io_slave_awid,
  input  logic [7:0]  io_slave_awlen,
  input  logic [2:0]  io_slave_awsize,
  input  logic [1:0]  io_slave_awburst,
  output logic        io_slave_wready,
  input  logic        io_slave_wvalid,
  input  logic [31:0] io_slave_wdata,
  input  logic [7:0]  io_slave_wstrb,
  input  logic        io_slave_wlast,
  input  logic        io_slave_bready,
  output logic        io_slave_bvalid,
  output logic [1:0]  io_slave_bresp,
  output logic [3:0]  io_slave_bid,
  input  logic        io_interrupt
);

  // Nothing in the core answers on the slave port
  assign io_slave_awready = 1'b0;
  assign io_slave_wready  = 1'b0;
  assign io_slave_bvalid  = 1'b0;
  assign io_slave_bresp   = 2'b00;
  assign io_slave_bid     = 4'h0;
  assign io_slave_arready = 1'b0;
  assign io_slave_rvalid  = 1'b0;
  assign io_slave_rresp   = 2'b00;
  assign io_slave_rdata   = 32'h0;
  assign io_slave_rlast   = 1'b0;
  assign io_slave_rid     = 4'h0;

  top_core #(
    .RESET_PC (RESET_PC),
    .IRQ_VEC  (IRQ_VEC)
  ) core_i (
    .clk    (clock),
    .arst_n (arst_n),
    .irq    (io_interrupt),
    .*                       // Master channels keep their names
  );

endmodule

// ==== hdl/top_core.sv ====
`timescale 1ns/1ps

module top_core #(
  parameter top_pkg::addr_t RESET_PC = 32'h0000_0000,
  parameter top_pkg::addr_t IRQ_VEC  = 32'h0000_0100
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        irq,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [31:0] io_master_araddr,
  output logic [3:0]  io_master_arid,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [1:0]  io_master_rresp,
  input  logic [31:0] io_master_rdata,
  input  logic        io_master_rlast,
  input  logic [3:0]  io_master_rid,
  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [31:0] io_master_awaddr,
  output logic [3:0]  io_master_awid,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [31:0] io_master_wdata,
  output logic [3:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [1:0]  io_master_bresp,
  input  logic [3:0]  io_master_bid
);
  import top_pkg::*;

  logic  req;
  logic  we;
  logic  done;
  addr_t addr;
  word_t wdata;
  word_t rdata;

  // Every transfer is one 4-byte beat with ID 0, so the attributes are fixed
  assign io_master_arid    = 4'h0;
  assign io_master_arlen   = 8'h00;
  assign io_master_arsize  = 3'd2;
  assign io_master_arburst = 2'b01;
  assign io_master_awid    = 4'h0;
  assign io_master_awlen   = 8'h00;
  assign io_master_awsize  = 3'd2;
  assign io_master_awburst = 2'b01;
  assign io_master_wstrb   = 4'hf;

  acc_cpu #(
    .RESET_PC (RESET_PC),
    .IRQ_VEC  (IRQ_VEC)
  ) cpu_i (
    .clk    (clk),
    .arst_n (arst_n),
    .irq    (irq),
    .req    (req),
    .we     (we),
    .addr   (addr),
    .wdata  (wdata),
    .done   (done),
    .rdata  (rdata)
  );

  axi_single_master bridge_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .done      (done),
    .rdata     (rdata),
    .arvalid   (io_master_arvalid),
    .arready   (io_master_arready),
    .araddr    (io_master_araddr),
    .rvalid    (io_master_rvalid),
    .rready    (io_master_rready),
    .rdata_in  (io_master_rdata),
    .awvalid   (io_master_awvalid),
    .awready   (io_master_awready),
    .awaddr    (io_master_awaddr),
    .wvalid    (io_master_wvalid),
    .wready    (io_master_wready),
    .wdata_out (io_master_wdata),
    .wlast     (io_master_wlast),
    .bvalid    (io_master_bvalid),
    .bready    (io_master_bready)
  );

endmodule

// ==== hdl/axi_single_master.sv ====
`timescale 1ns/1ps

module axi_single_master (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           req,
  input  logic           we,
  input  top_pkg::addr_t addr,
  input  top_pkg::word_t wdata,
  output logic           done,
  output top_pkg::word_t rdata,
  output logic           arvalid,
  input  logic           arready,
  output top_pkg::addr_t araddr,
  input  logic           rvalid,
  output logic           rready,
  input  top_pkg::word_t rdata_in,
  output logic           awvalid,
  input  logic           awready,
  output top_pkg::addr_t awaddr,
  output logic           wvalid,
  input  logic           wready,
  output top_pkg::word_t wdata_out,
  output logic           wlast,
  input  logic           bvalid,
  output logic           bready
);
  import top_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RD,
    WR
  } state_e;

  state_e state;
  addr_t  addr_q;
  word_t  wdata_q;
  logic   r_hs;
  logic   b_hs;
  logic   aw_clear;
  logic   w_clear;

  assign r_hs     = rvalid && rready;
  assign b_hs     = bvalid && bready;
  assign aw_clear = !awvalid || awready;  // AW accepted by the end of this cycle
  assign w_clear  = !wvalid || wready;

  assign done      = r_hs || b_hs;
  assign rdata     = rdata_in;
  assign araddr    = addr_q;
  assign awaddr    = addr_q;
  assign wdata_out = wdata_q;
  assign wlast     = wvalid;  // Single beat, so the only beat is the last

  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req && we) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= WR;
          end else if (req) begin
            arvalid <= 1'b1;
            state   <= RD;
          end
        end
        RD: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
          if (r_hs) begin
            rready <= 1'b0;
            state  <= IDLE;
          end
        end
        WR: begin
          if (awvalid && awready) begin
            awvalid <= 1'b0;
          end
          if (wvalid && wready) begin
            wvalid <= 1'b0;
          end
          if (b_hs) begin
            bready <= 1'b0;
            state  <= IDLE;
          end else if (!bready && aw_clear && w_clear) begin
            bready <= 1'b1;  // Both address and data are in
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/acc_cpu.sv ====
`timescale 1ns/1ps

module acc_cpu #(
  parameter top_pkg::addr_t RESET_PC = 32'h0000_0000,
  parameter top_pkg::addr_t IRQ_VEC  = 32'h0000_0100
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           irq,
  output logic           req,
  output logic           we,
  output top_pkg::addr_t addr,
  output top_pkg::word_t wdata,
  input  logic           done,
  input  top_pkg::word_t rdata
);
  import top_pkg::*;

  typedef enum logic [1:0] {
    FETCH,
    DECODE,
    MEM,
    HALTED
  } state_e;

  state_e state;
  logic   fetch_busy;  // Fetch request sent, waiting for done
  logic   in_irq;
  addr_t  pc;
  addr_t  epc;
  word_t  acc;
  instr_u ir;
  word_t  imm_sext;
  addr_t  mem_addr;
  addr_t  next_pc;
  logic   retire;

  assign imm_sext = {{4{ir.imm.imm[27]}}, ir.imm.imm};
  assign mem_addr = {4'h0, ir.mem.addr[27:2], 2'b00};

  // Instruction boundary and the pc that follows it
  always_comb begin
    retire  = 1'b0;
    next_pc = pc + 32'd4;
    if (state == DECODE) begin
      case (ir.imm.op)
        LDI, ADDI: retire = 1'b1;
        BNZ: begin
          retire = 1'b1;
          if (acc != '0) begin
            next_pc = mem_addr;
          end
        end
        RETI: begin
          retire  = 1'b1;
          next_pc = epc;
        end
        default: retire = 1'b0;
      endcase
    end else if (state == MEM) begin
      retire = done;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= FETCH;
      fetch_busy <= 1'b0;
      in_irq     <= 1'b0;
      pc         <= RESET_PC;
      epc        <= '0;
      acc        <= '0;
      req        <= 1'b0;
      we         <= 1'b0;
    end else begin
      req <= 1'b0;
      case (state)
        FETCH: begin
          if (!fetch_busy) begin
            req        <= 1'b1;
            we         <= 1'b0;
            fetch_busy <= 1'b1;
          end else if (done) begin
            fetch_busy <= 1'b0;
            state      <= DECODE;
          end
        end
        DECODE: begin
          case (ir.imm.op)
            LDI:  acc <= imm_sext;
            ADDI: acc <= acc + imm_sext;
            LOAD, ADD, STORE: begin
              req   <= 1'b1;
              we    <= (ir.mem.op == STORE);
              state <= MEM;
            end
            RETI: in_irq <= 1'b0;
            BNZ:  ;
            default: state <= HALTED;  // HALT, and any undefined opcode
          endcase
        end
        MEM: begin
          if (done && ir.mem.op == LOAD) begin
            acc <= rdata;
          end else if (done && ir.mem.op == ADD) begin
            acc <= acc + rdata;
          end
        end
        default: state <= HALTED;
      endcase

      if (retire) begin
        state <= FETCH;
        if (irq && !in_irq) begin  // Take the interrupt instead of next_pc
          epc    <= next_pc;
          pc     <= IRQ_VEC;
          in_irq <= 1'b1;
        end else begin
          pc <= next_pc;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH && !fetch_busy) begin
      addr <= pc;
    end else if (state == DECODE) begin
      addr  <= mem_addr;
      wdata <= acc;
    end
    if (state == FETCH && fetch_busy && done) begin
      ir <= rdata;
    end
  end

endmodule

// ==== hdl/top_pkg.sv ====
package top_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  typedef enum logic [3:0] {
    LDI   = 4'h0,
    ADDI  = 4'h1,
    LOAD  = 4'h2,
    ADD   = 4'h3,
    STORE = 4'h4,
    BNZ   = 4'h5,
    RETI  = 4'h6,
    HALT  = 4'h7
  } opcode_e;

  typedef struct packed {
    opcode_e            op;
    logic signed [27:0] imm;  // Sign extended to 32 bits on use
  } imm_fmt_t;

  typedef struct packed {
    opcode_e     op;
    logic [27:0] addr;  // Byte address of a word, upper nibble is zero
  } mem_fmt_t;

  // Both views cover the same 32-bit instruction word
  typedef union packed {
    imm_fmt_t imm;
    mem_fmt_t mem;
  } instr_u;

  localparam logic [1:0] resp_okay = 2'b00;

endpackage
